/* logic/cpu_settings.svh */
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// Datapath bus width
`define CPU_DATA_W 8

// Opcode register and micro-op step counter widths
`define CPU_OPCODE_W 6
`define CPU_STEP_W 5

// Microcode address is condition bit, opcode, step
`define CPU_UADDR_W 12
`define CPU_UWORD_W 32

// APB word address width, one bit above the store
`define CPU_PADDR_W 13

// Boot control register sits just past the last microword
`define CPU_BOOT_ADDR 13'h1000

`endif

/* logic/datapath_pkg.sv */
`include "cpu_settings.svh"

package datapath_pkg;

  // One byte on the shared bus
  typedef logic [`CPU_DATA_W-1:0] data_t;

  // Math/logic unit operations
  typedef enum logic [3:0] {
    mlu_add    = 4'd0,
    mlu_sub    = 4'd1,
    mlu_and    = 4'd2,
    mlu_or     = 4'd3,
    mlu_xor    = 4'd4,
    mlu_pass_a = 4'd5,
    mlu_not_a  = 4'd6
  } mlu_op_t;

  // Single-bit shifter modes, applied to tmp0
  typedef enum logic [1:0] {
    shift_pass   = 2'd0,
    shift_left   = 2'd1,
    shift_right  = 2'd2,
    shift_rotate = 2'd3
  } shift_mode_t;

  // Flags describe the MLU result only
  typedef struct packed {
    logic zero;
    logic carry;
    logic negative;
  } flags_t;

endpackage

/* logic/ctrl_pkg.sv */
`include "cpu_settings.svh"

package ctrl_pkg;
  import datapath_pkg::*;

  typedef logic [`CPU_OPCODE_W-1:0] opcode_t;
  typedef logic [`CPU_STEP_W-1:0] step_t;

  // In plane, who captures the bus on the next edge
  typedef enum logic [2:0] {
    in_none    = 3'd0,
    in_tmp0    = 3'd1,
    in_tmp1    = 3'd2,
    in_opcode  = 3'd3,
    in_ext_out = 3'd4
  } in_plane_t;

  // Out plane, who drives the bus
  typedef enum logic [3:0] {
    out_none      = 4'd0,
    out_tmp0      = 4'd1,
    out_tmp1      = 4'd2,
    out_mlu       = 4'd3,
    out_shifter   = 4'd4,
    out_ctrl_data = 4'd5,
    out_ext_in    = 4'd6
  } out_plane_t;

  // Housekeeping actions
  typedef enum logic [1:0] {
    misc_none           = 2'd0,
    misc_step_reset     = 2'd1,
    misc_set_int_enable = 2'd2
  } misc_plane_t;

  // Condition bit feeding the top of the microcode address
  typedef enum logic [1:0] {
    cond_zero      = 2'd0,
    cond_carry     = 2'd1,
    cond_negative  = 2'd2,
    cond_interrupt = 2'd3
  } cond_sel_t;

  // Whatever is left of the word after the defined fields
  localparam int uword_spare_w = `CPU_UWORD_W - `CPU_DATA_W - $bits(out_plane_t)
                                 - $bits(in_plane_t) - $bits(misc_plane_t) - $bits(mlu_op_t)
                                 - $bits(shift_mode_t) - 1 - $bits(cond_sel_t);

  // ctrl_data in the top byte, spare bits at the bottom
  typedef struct packed {
    logic [`CPU_DATA_W-1:0]   ctrl_data;
    out_plane_t               out_plane;
    in_plane_t                in_plane;
    misc_plane_t              misc_plane;
    mlu_op_t                  mlu_op;
    shift_mode_t              shift_mode;
    logic                     shift_arith;
    cond_sel_t                cond_sel;
    logic [uword_spare_w-1:0] spare;
  } microword_t;

endpackage

/* logic/bus_register.sv */
module bus_register #(
  parameter type payload_t = datapath_pkg::data_t
) (
  input  logic     n_clk,
  input  logic     n_rst,
  input  logic     load,
  input  payload_t d,
  output payload_t q
);

  // Captures the bus only on strobed edges
  always_ff @(posedge n_clk or negedge n_rst) begin
    if (!n_rst) begin
      q <= '0;
    end else if (load) begin
      q <= d;
    end
  end

endmodule

/* logic/mlu_shifter.sv */
`include "cpu_settings.svh"

module mlu_shifter (
  input  datapath_pkg::data_t       a,
  input  datapath_pkg::data_t       b,
  input  datapath_pkg::mlu_op_t     op,
  input  datapath_pkg::shift_mode_t shift_mode,
  input  logic                      shift_arith,
  output datapath_pkg::data_t       mlu_result,
  output datapath_pkg::data_t       shift_result,
  output datapath_pkg::flags_t      flags
);
  import datapath_pkg::*;

  // One extra bit on top catches carry or borrow
  logic [`CPU_DATA_W:0] wide;

  always_comb begin
    case (op)
      mlu_add:    wide = {1'b0, a} + {1'b0, b};
      // Top bit set means a borrow
      mlu_sub:    wide = {1'b0, a} - {1'b0, b};
      mlu_and:    wide = {1'b0, a & b};
      mlu_or:     wide = {1'b0, a | b};
      mlu_xor:    wide = {1'b0, a ^ b};
      mlu_pass_a: wide = {1'b0, a};
      mlu_not_a:  wide = {1'b0, ~a};
      default:    wide = '0;
    endcase
  end

  assign mlu_result = wide[`CPU_DATA_W-1:0];

  always_comb begin
    flags.zero     = mlu_result == '0;
    flags.carry    = wide[`CPU_DATA_W];
    flags.negative = mlu_result[`CPU_DATA_W-1];
  end

  // Shifter works on tmp0 alone
  always_comb begin
    case (shift_mode)
      shift_left:   shift_result = {a[`CPU_DATA_W-2:0], 1'b0};
      // Arithmetic right keeps the sign bit
      shift_right:  shift_result = {shift_arith & a[`CPU_DATA_W-1], a[`CPU_DATA_W-1:1]};
      // Rotate left, old bit 7 wraps into bit 0
      shift_rotate: shift_result = {a[`CPU_DATA_W-2:0], a[`CPU_DATA_W-1]};
      default:      shift_result = a;
    endcase
  end

endmodule

/* logic/microcode_store.sv */
`include "cpu_settings.svh"

module microcode_store (
  input  logic                    n_clk,
  input  logic                    n_rst,
  input  logic                    psel,
  input  logic                    penable,
  input  logic                    pwrite,
  input  logic [`CPU_PADDR_W-1:0] paddr,
  input  logic [`CPU_UWORD_W-1:0] pwdata,
  output logic [`CPU_UWORD_W-1:0] prdata,
  output logic                    pready,
  output logic                    pslverr,
  input  logic [`CPU_UADDR_W-1:0] uaddr,
  output ctrl_pkg::microword_t    uword,
  output logic                    booted
);
  import ctrl_pkg::*;

  localparam int store_depth = 1 << `CPU_UADDR_W;

  microword_t mem [0:store_depth-1];
  logic access;
  logic in_store;
  logic is_boot;

  // Transfer completes in the access phase, never a wait state
  assign access = psel & penable;
  assign pready = 1'b1;

  // Store occupies the lower half of the APB window
  assign in_store = paddr < store_depth;
  assign is_boot  = paddr == `CPU_BOOT_ADDR;

  // Store writes rejected once booted
  assign pslverr = access & pwrite & in_store & booted;

  always_ff @(posedge n_clk) begin
    if (access && pwrite && in_store && !booted) begin
      mem[paddr[`CPU_UADDR_W-1:0]] <= pwdata;
    end
  end

  // Boot flag gates both bootstrap writes and execution
  always_ff @(posedge n_clk or negedge n_rst) begin
    if (!n_rst) begin
      booted <= 1'b0;
    end else if (access && pwrite && is_boot) begin
      booted <= pwdata[0];
    end
  end

  // Read side, unmapped addresses give zero
  always_comb begin
    if (in_store) begin
      prdata = mem[paddr[`CPU_UADDR_W-1:0]];
    end else if (is_boot) begin
      prdata = {{(`CPU_UWORD_W-1){1'b0}}, booted};
    end else begin
      prdata = '0;
    end
  end

  // Core fetch port
  assign uword = mem[uaddr];

endmodule

/* logic/control_logic.sv */
`include "cpu_settings.svh"

module control_logic (
  input  logic                      n_clk,
  input  logic                      n_rst,
  input  logic                      booted,
  input  datapath_pkg::data_t       bus,
  input  datapath_pkg::flags_t      flags,
  input  logic                      irq,
  output logic [`CPU_UADDR_W-1:0]   uaddr,
  input  ctrl_pkg::microword_t      uword,
  output logic                      tmp0_load,
  output logic                      tmp1_load,
  output logic                      ext_out_load,
  output ctrl_pkg::out_plane_t      out_sel,
  output datapath_pkg::mlu_op_t     mlu_op,
  output datapath_pkg::shift_mode_t shift_mode,
  output logic                      shift_arith,
  output datapath_pkg::data_t       ctrl_data
);
  import ctrl_pkg::*;

  microword_t uword_q;
  step_t      step;
  opcode_t    opcode;
  logic       opcode_load;
  logic       irq_pending;
  logic       int_enable;
  logic       cond;
  logic       step_reset;
  logic       set_int_enable;

  // Microword latch held at all-none codes until boot
  always_ff @(posedge n_clk or negedge n_rst) begin
    if (!n_rst) begin
      uword_q <= '0;
    end else if (!booted) begin
      uword_q <= '0;
    end else begin
      uword_q <= uword;
    end
  end

  // Misc plane
  assign step_reset     = uword_q.misc_plane == misc_step_reset;
  assign set_int_enable = uword_q.misc_plane == misc_set_int_enable;

  // Step counter, one micro step per cycle
  always_ff @(posedge n_clk or negedge n_rst) begin
    if (!n_rst) begin
      step <= '0;
    end else if (!booted || step_reset) begin
      step <= '0;
    end else begin
      step <= step + 1'b1;
    end
  end

  // Pending irq sampled every edge; enable written from ctrl_data bit 0
  always_ff @(posedge n_clk or negedge n_rst) begin
    if (!n_rst) begin
      irq_pending <= 1'b0;
      int_enable  <= 1'b0;
    end else begin
      irq_pending <= irq;
      if (set_int_enable) begin
        int_enable <= uword_q.ctrl_data[0];
      end
    end
  end

  // Condition select
  always_comb begin
    case (uword_q.cond_sel)
      cond_zero:     cond = flags.zero;
      cond_carry:    cond = flags.carry;
      cond_negative: cond = flags.negative;
      default:       cond = irq_pending & int_enable;
    endcase
  end

  // Opcode always comes off the bus
  bus_register #(
    .payload_t(opcode_t)
  ) u_opcode (
    .n_clk(n_clk),
    .n_rst(n_rst),
    .load(opcode_load),
    .d(bus[`CPU_OPCODE_W-1:0]),
    .q(opcode)
  );

  assign uaddr = {cond, opcode, step};

  // In plane into one-hot load strobes
  always_comb begin
    tmp0_load    = 1'b0;
    tmp1_load    = 1'b0;
    opcode_load  = 1'b0;
    ext_out_load = 1'b0;
    case (uword_q.in_plane)
      in_tmp0:    tmp0_load = 1'b1;
      in_tmp1:    tmp1_load = 1'b1;
      in_opcode:  opcode_load = 1'b1;
      in_ext_out: ext_out_load = 1'b1;
      default:    ;
    endcase
  end

  // Out plane code goes straight to the bus select
  assign out_sel = uword_q.out_plane;

  // Datapath control fields
  assign mlu_op      = uword_q.mlu_op;
  assign shift_mode  = uword_q.shift_mode;
  assign shift_arith = uword_q.shift_arith;
  assign ctrl_data   = uword_q.ctrl_data;

endmodule

/* logic/cpu_core.sv */
`include "cpu_settings.svh"

module cpu_core (
  input  logic                    n_clk,
  input  logic                    n_rst,
  input  logic                    psel,
  input  logic                    penable,
  input  logic                    pwrite,
  input  logic [`CPU_PADDR_W-1:0] paddr,
  input  logic [`CPU_UWORD_W-1:0] pwdata,
  output logic [`CPU_UWORD_W-1:0] prdata,
  output logic                    pready,
  output logic                    pslverr,
  input  logic                    irq,
  input  datapath_pkg::data_t     ext_in,
  output datapath_pkg::data_t     ext_out,
  output logic                    ext_out_valid
);
  import datapath_pkg::*;
  import ctrl_pkg::*;

  logic [`CPU_UADDR_W-1:0] uaddr;
  microword_t  uword;
  logic        booted;
  data_t       bus;
  data_t       tmp0;
  data_t       tmp1;
  data_t       mlu_result;
  data_t       shift_result;
  data_t       ctrl_data;
  flags_t      flags;
  logic        tmp0_load;
  logic        tmp1_load;
  logic        ext_out_load;
  out_plane_t  out_sel;
  mlu_op_t     mlu_op;
  shift_mode_t shift_mode;
  logic        shift_arith;

  microcode_store u_store (.*);

  control_logic u_ctrl (.*);

  mlu_shifter u_mlu (
    .a(tmp0),
    .b(tmp1),
    .op(mlu_op),
    .*
  );

  // Temporaries, MLU operands a and b
  bus_register #(.payload_t(data_t)) u_tmp0 (.load(tmp0_load), .d(bus), .q(tmp0), .*);
  bus_register #(.payload_t(data_t)) u_tmp1 (.load(tmp1_load), .d(bus), .q(tmp1), .*);

  // Bus source select
  always_comb begin
    case (out_sel)
      out_tmp0:      bus = tmp0;
      out_tmp1:      bus = tmp1;
      out_mlu:       bus = mlu_result;
      out_shifter:   bus = shift_result;
      out_ctrl_data: bus = ctrl_data;
      out_ext_in:    bus = ext_in;
      default:       bus = '0;
    endcase
  end

  // Output port, valid for the one cycle after a load
  always_ff @(posedge n_clk or negedge n_rst) begin
    if (!n_rst) begin
      ext_out       <= '0;
      ext_out_valid <= 1'b0;
    end else begin
      ext_out_valid <= ext_out_load;
      if (ext_out_load) begin
        ext_out <= bus;
      end
    end
  end

endmodule

/* tests/cpu_core_asserts.sv */
module cpu_core_asserts (
  input logic n_clk,
  input logic n_rst,
  input logic psel,
  input logic penable,
  input logic pready,
  input logic pslverr,
  input logic ext_out_valid
);

  // No wait states on the APB port
  pready_high: assert property (@(posedge n_clk) disable iff (!n_rst) pready)
    else $error("pready dropped low");

  // Slave error only while in the access phase
  pslverr_access: assert property (@(posedge n_clk) disable iff (!n_rst)
    pslverr |-> (psel && penable))
    else $error("pslverr outside an access phase");

  // Output strobe lasts a single cycle
  valid_pulse: assert property (@(posedge n_clk) disable iff (!n_rst)
    ext_out_valid |=> !ext_out_valid)
    else $error("ext_out_valid held for two cycles");

endmodule

bind cpu_core cpu_core_asserts u_asserts (.*);

/* tests/cpu_core_tb.sv */
`include "cpu_settings.svh"

module cpu_core_tb;
  import datapath_pkg::*;
  import ctrl_pkg::*;

  localparam int wait_limit = 50;
  localparam data_t const_a = 8'h5a;
  localparam data_t const_b = 8'hc3;

  logic n_clk;
  logic n_rst;
  logic psel;
  logic penable;
  logic pwrite;
  logic [`CPU_PADDR_W-1:0] paddr;
  logic [`CPU_UWORD_W-1:0] pwdata;
  logic [`CPU_UWORD_W-1:0] prdata;
  logic pready;
  logic pslverr;
  logic irq;
  data_t ext_in;
  data_t ext_out;
  logic ext_out_valid;
  int errors;
  int checks;

  cpu_core uut (.*);

  initial n_clk = 1'b0;
  always #10 n_clk = ~n_clk;

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("errors: %0d checks: %0d", errors, checks);
    $display("test failed");
    $finish;
  endtask

  task automatic check(input string name, input logic [31:0] expected, input logic [31:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("Error: %s expected %h actual %h", name, expected, actual);
    end
  endtask

  // Setup on one falling edge, access on the next, done on the rising edge
  task automatic apb_xfer(input logic wr, input logic [12:0] addr, input logic [31:0] data,
                          output logic [31:0] rdata, output logic err);
    int waited;
    @(negedge n_clk);
    psel = 1'b1;
    pwrite = wr;
    paddr = addr;
    pwdata = data;
    penable = 1'b0;
    @(negedge n_clk);
    penable = 1'b1;
    waited = 0;
    #1;
    while (!pready && waited < wait_limit) begin
      @(negedge n_clk);
      #1;
      waited++;
    end
    if (!pready) begin
      abort_run("APB transfer never saw pready");
    end else begin
      rdata = prdata;
      err = pslverr;
      @(posedge n_clk);
      @(negedge n_clk);
      psel = 1'b0;
      penable = 1'b0;
      pwrite = 1'b0;
    end
  endtask

  task automatic apb_write(input logic [12:0] addr, input logic [31:0] data, output logic err);
    logic [31:0] unused;
    apb_xfer(1'b1, addr, data, unused, err);
  endtask

  task automatic apb_read(input logic [12:0] addr, output logic [31:0] data);
    logic err;
    apb_xfer(1'b0, addr, 32'h0, data, err);
  endtask

  function automatic microword_t mw(input out_plane_t op_out, input in_plane_t op_in,
                                    input misc_plane_t misc, input mlu_op_t alu,
                                    input shift_mode_t sm, input logic arith,
                                    input cond_sel_t cs, input data_t data);
    microword_t w;
    w = '0;
    w.ctrl_data = data;
    w.out_plane = op_out;
    w.in_plane = op_in;
    w.misc_plane = misc;
    w.mlu_op = alu;
    w.shift_mode = sm;
    w.shift_arith = arith;
    w.cond_sel = cs;
    return w;
  endfunction

  // Store address is condition, opcode, step
  task automatic load_uword(input logic cond, input opcode_t op, input step_t st,
                            input microword_t w);
    logic err;
    apb_write({1'b0, cond, op, st}, w, err);
  endtask

  // Same word on both condition halves
  task automatic load_step(input opcode_t op, input step_t st, input microword_t w);
    load_uword(1'b0, op, st, w);
    load_uword(1'b1, op, st, w);
  endtask

  // Reset, then opcode 0 fetches from ext_in with a none word in flight
  task automatic reset_dut();
    @(negedge n_clk);
    n_rst = 1'b0;
    repeat (5) @(negedge n_clk);
    n_rst = 1'b1;
    load_step(0, 0, mw(out_ext_in, in_opcode, misc_step_reset, mlu_add, shift_pass, 0,
                       cond_zero, 0));
    load_step(0, 1, '0);
  endtask

  // Opcode byte during fetch, then operands for steps 0 and 1
  task automatic boot_feed(input data_t a, input data_t b);
    logic err;
    ext_in = 8'h01;
    apb_write(`CPU_BOOT_ADDR, 32'h1, err);
    repeat (3) @(negedge n_clk);
    ext_in = a;
    @(negedge n_clk);
    ext_in = b;
  endtask

  task automatic wait_ext_out(input string name, input data_t expected);
    int waited;
    waited = 0;
    @(negedge n_clk);
    while (!ext_out_valid && waited < wait_limit) begin
      @(negedge n_clk);
      waited++;
    end
    if (!ext_out_valid) begin
      abort_run({name, ": ext_out_valid never came"});
    end else begin
      check(name, expected, ext_out);
    end
  endtask

  function automatic data_t expect_mlu(input mlu_op_t op, input data_t a, input data_t b);
    case (op)
      mlu_add:    return a + b;
      mlu_sub:    return a - b;
      mlu_and:    return a & b;
      mlu_or:     return a | b;
      mlu_xor:    return a ^ b;
      mlu_not_a:  return ~a;
      default:    return a;
    endcase
  endfunction

  function automatic data_t expect_shift(input shift_mode_t sm, input logic arith, input data_t a);
    case (sm)
      shift_left:   return a << 1;
      shift_right:  return arith ? {a[7], a[7:1]} : a >> 1;
      shift_rotate: return {a[6:0], a[7]};
      default:      return a;
    endcase
  endfunction

  // Opcode 1 loads tmp0 and tmp1 from ext_in and sends the result to ext_out
  task automatic alu_case(input string name, input out_plane_t src, input mlu_op_t op,
                          input shift_mode_t sm, input logic arith, input data_t a,
                          input data_t b);
    data_t expected;
    expected = (src == out_mlu) ? expect_mlu(op, a, b) : expect_shift(sm, arith, a);
    reset_dut();
    load_step(1, 0, mw(out_ext_in, in_tmp0, misc_none, mlu_add, shift_pass, 0, cond_zero, 0));
    load_step(1, 1, mw(out_ext_in, in_tmp1, misc_none, mlu_add, shift_pass, 0, cond_zero, 0));
    load_step(1, 2, mw(src, in_ext_out, misc_none, op, sm, arith, cond_zero, 0));
    load_step(1, 3, mw(out_none, in_none, misc_step_reset, mlu_add, shift_pass, 0, cond_zero, 0));
    load_step(1, 4, '0);
    boot_feed(a, b);
    wait_ext_out(name, expected);
  endtask

  // Sub sets the zero flag, which picks the next word
  task automatic cond_case(input string name, input data_t a, input data_t b);
    reset_dut();
    load_step(1, 0, mw(out_ext_in, in_tmp0, misc_none, mlu_add, shift_pass, 0, cond_zero, 0));
    load_step(1, 1, mw(out_ext_in, in_tmp1, misc_none, mlu_add, shift_pass, 0, cond_zero, 0));
    load_step(1, 2, mw(out_none, in_none, misc_none, mlu_sub, shift_pass, 0, cond_zero, 0));
    load_uword(1'b1, 1, 3, mw(out_ctrl_data, in_ext_out, misc_step_reset, mlu_add, shift_pass,
                              0, cond_zero, const_a));
    load_uword(1'b0, 1, 3, mw(out_ctrl_data, in_ext_out, misc_step_reset, mlu_add, shift_pass,
                              0, cond_zero, const_b));
    load_step(1, 4, '0);
    boot_feed(a, b);
    wait_ext_out(name, (a == b) ? const_a : const_b);
  endtask

  // irq level and interrupt enable together pick the word that follows
  task automatic irq_case(input string name, input logic en, input logic level);
    irq = level;
    reset_dut();
    load_step(1, 0, mw(out_none, in_none, misc_set_int_enable, mlu_add, shift_pass, 0,
                       cond_zero, {7'h0, en}));
    load_step(1, 1, mw(out_none, in_none, misc_none, mlu_add, shift_pass, 0, cond_interrupt, 0));
    load_uword(1'b1, 1, 2, mw(out_ctrl_data, in_ext_out, misc_step_reset, mlu_add, shift_pass,
                              0, cond_zero, const_a));
    load_uword(1'b0, 1, 2, mw(out_ctrl_data, in_ext_out, misc_step_reset, mlu_add, shift_pass,
                              0, cond_zero, const_b));
    load_step(1, 3, '0);
    boot_feed(8'h00, 8'h00);
    wait_ext_out(name, (en && level) ? const_a : const_b);
    irq = 1'b0;
  endtask

  task automatic bootstrap_test();
    logic [31:0] w0;
    logic [31:0] w1;
    logic [31:0] rd;
    logic err;
    w0 = $urandom;
    w1 = $urandom;
    reset_dut();
    check("reset ext_out_valid", 0, ext_out_valid);
    check("reset ext_out", 0, ext_out);
    apb_write(13'h0123, w0, err);
    check("pslverr before boot", 0, err);
    apb_write(13'h0fff, w1, err);
    apb_read(13'h0123, rd);
    check("readback low", w0, rd);
    apb_read(13'h0fff, rd);
    check("readback high", w1, rd);
    apb_write(`CPU_BOOT_ADDR, 32'h1, err);
    apb_read(`CPU_BOOT_ADDR, rd);
    check("boot flag", 1, rd);
    apb_write(13'h0123, ~w0, err);
    check("pslverr after boot", 1, err);
    apb_read(13'h0123, rd);
    check("store kept", w0, rd);
  endtask

  initial begin
    data_t a;
    data_t b;
    errors = 0;
    checks = 0;
    n_rst = 1'b0;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = '0;
    irq = 1'b0;
    ext_in = '0;
    void'($urandom(32'h8ca217b2));

    bootstrap_test();

    a = $urandom;
    b = $urandom;
    alu_case("add", out_mlu, mlu_add, shift_pass, 0, a, b);
    alu_case("sub", out_mlu, mlu_sub, shift_pass, 0, a, b);
    alu_case("and", out_mlu, mlu_and, shift_pass, 0, a, b);
    alu_case("or", out_mlu, mlu_or, shift_pass, 0, a, b);
    alu_case("xor", out_mlu, mlu_xor, shift_pass, 0, a, b);
    alu_case("not_a", out_mlu, mlu_not_a, shift_pass, 0, a, b);
    alu_case("shift left", out_shifter, mlu_add, shift_left, 0, a, b);
    alu_case("rotate", out_shifter, mlu_add, shift_rotate, 0, a, b);
    // Sign bit forced so arithmetic right has something to keep
    a = a | 8'h80;
    alu_case("shift right", out_shifter, mlu_add, shift_right, 0, a, b);
    alu_case("shift right arith", out_shifter, mlu_add, shift_right, 1, a, b);

    cond_case("cond equal", a, a);
    cond_case("cond unequal", a, a ^ 8'h01);

    irq_case("irq disabled", 1'b0, 1'b1);
    irq_case("irq enabled", 1'b1, 1'b1);
    irq_case("irq enabled idle", 1'b1, 1'b0);

    $display("errors: %0d checks: %0d", errors, checks);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

/* src.f */
+incdir+logic
logic/datapath_pkg.sv
logic/ctrl_pkg.sv
logic/bus_register.sv
logic/mlu_shifter.sv
logic/microcode_store.sv
logic/control_logic.sv
logic/cpu_core.sv
tests/cpu_core_asserts.sv
tests/cpu_core_tb.sv

/* build.sh */
#!/usr/bin/env bash
# Build and run the cpu_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f src.f --top-module cpu_core_tb \
  --Mdir obj_dir -o cpu_core_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/cpu_core_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^test passed$" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1
